/* hdl/msg_pkg.sv */
package msg_pkg;

    // one message word on every link
    localparam int MSG_WIDTH = 64;

    // destination codes
    localparam logic [7:0] DEST_ROOT      = 8'h00;
    localparam logic [7:0] DEST_BROADCAST = 8'hff;

    // header codes
    localparam logic [7:0] HEADER_DECODE_BLOCK = 8'h02;
    localparam logic [7:0] HEADER_RESULT       = 8'h05;
    localparam logic [7:0] HEADER_SUMMARY      = 8'h06;

    // command flags live in the low 16 bits
    localparam int FLAG_REPORT_ALL_BIT = 3;

    // syndrome sits at bits 47:16 of a command
    localparam int SYNDROME_LSB   = 16;
    localparam int SYNDROME_WIDTH = 32;

    // same 64 bits read as a command or as a result
    typedef union packed {
        struct packed {
            logic [7:0]                dest;
            logic [7:0]                header;
            logic [SYNDROME_WIDTH-1:0] syndrome;
            logic [15:0]               flags;
        } cmd;
        struct packed {
            logic [7:0]  dest;
            logic [7:0]  header;
            logic [7:0]  leaf_id;
            logic [7:0]  reserved;
            logic [15:0] defects;
            logic [15:0] cycles;
        } res;
    } msg_word_u;

endpackage

/* hdl/tree_pkg.sv */
package tree_pkg;

    // two leaves under the root
    localparam int NUM_CHILDREN = 2;

    // syndrome bits handled by one leaf
    localparam int SLICE_WIDTH = 16;

    // bits left to scan after the first one
    localparam int SCAN_COUNT_WIDTH = $clog2(SLICE_WIDTH);

    // defect and cycle fields of a result
    localparam int COUNT_WIDTH = 16;

    // must hold 0 up to NUM_CHILDREN
    localparam int RETURN_COUNT_WIDTH = $clog2(NUM_CHILDREN + 1);

    typedef enum logic [1:0] {
        STAGE_IDLE         = 2'd0,
        STAGE_WAIT_RESULTS = 2'd1
    } root_stage_e;

endpackage

/* hdl/leaf_decoder.sv */
module leaf_decoder #(
    parameter int LEAF_ID = 0
) (
    input  logic                         clk,
    input  logic                         reset,

    input  logic [msg_pkg::MSG_WIDTH-1:0] cmd_data,
    input  logic                         cmd_valid,
    output logic                         cmd_ready,

    output logic [msg_pkg::MSG_WIDTH-1:0] res_data,
    output logic                         res_valid,
    input  logic                         res_ready
);

    import msg_pkg::*;
    import tree_pkg::*;

    logic busy;
    logic pair_pend;
    logic [SLICE_WIDTH-1:0] shreg;
    logic [SCAN_COUNT_WIDTH-1:0] remaining;
    logic [COUNT_WIDTH-1:0] defects;
    logic [COUNT_WIDTH-1:0] cycles;

    logic [SLICE_WIDTH-1:0] slice_in;
    logic take_bit;
    logic bit_in;
    logic next_pend;
    logic [SCAN_COUNT_WIDTH-1:0] next_rem;
    logic last_work;
    msg_word_u res_word;

    assign slice_in = cmd_data[SYNDROME_LSB + LEAF_ID * SLICE_WIDTH +: SLICE_WIDTH];

    assign cmd_ready = !busy && !res_valid;

    // a pairing cycle blocks the shift
    assign take_bit  = !pair_pend;
    assign bit_in    = take_bit && shreg[0];
    assign next_pend = bit_in;
    assign next_rem  = take_bit ? remaining - 1'b1 : remaining;
    assign last_work = !next_pend && (next_rem == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            pair_pend <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            if (cmd_valid && cmd_ready) begin
                // capture cycle already looks at bit 0
                busy      <= 1'b1;
                pair_pend <= slice_in[0];
                shreg     <= slice_in >> 1;
                remaining <= SCAN_COUNT_WIDTH'(SLICE_WIDTH - 1);
                defects   <= COUNT_WIDTH'(slice_in[0]);
                cycles    <= COUNT_WIDTH'(1);
            end else if (busy) begin
                cycles    <= cycles + 1'b1;
                pair_pend <= next_pend;
                remaining <= next_rem;
                if (take_bit) begin
                    shreg   <= shreg >> 1;
                    defects <= defects + COUNT_WIDTH'(bit_in);
                end
                if (last_work) begin
                    busy      <= 1'b0;
                    res_valid <= 1'b1;
                end
            end else if (res_valid && res_ready) begin
                res_valid <= 1'b0;
            end
        end
    end

    always_comb begin
        res_word = '0;
        res_word.res.dest    = DEST_ROOT;
        res_word.res.header  = HEADER_RESULT;
        res_word.res.leaf_id = 8'(LEAF_ID);
        res_word.res.defects = defects;
        res_word.res.cycles  = cycles;
    end

    assign res_data = res_word;

    // result held until the hub takes it
    a_res_stable: assert property (
        @(posedge clk) disable iff (reset)
        (res_valid && !res_ready) |=> (res_valid && $stable(res_data))
    );

endmodule

/* hdl/child_link_hub.sv */
module child_link_hub (
    input  logic                         clk,
    input  logic                         reset,

    // broadcast side
    input  logic                         bcast_valid,
    output logic                         bcast_ready,
    output logic                         cmd_valid,
    input  logic                         cmd0_ready,
    input  logic                         cmd1_ready,

    // leaf results
    input  logic [msg_pkg::MSG_WIDTH-1:0] res0_data,
    input  logic                         res0_valid,
    output logic                         res0_ready,
    input  logic [msg_pkg::MSG_WIDTH-1:0] res1_data,
    input  logic                         res1_valid,
    output logic                         res1_ready,

    // merged stream to the root
    output logic [msg_pkg::MSG_WIDTH-1:0] up_data,
    output logic                         up_valid,
    input  logic                         up_ready
);

    logic grant;
    logic pick1;

    // both leaves must take the command together
    assign bcast_ready = cmd0_ready && cmd1_ready;
    assign cmd_valid   = bcast_valid && bcast_ready;

    // grant only matters when both are waiting
    assign pick1 = (res0_valid && res1_valid) ? grant : res1_valid;

    assign up_data    = pick1 ? res1_data : res0_data;
    assign up_valid   = res0_valid || res1_valid;
    assign res0_ready = up_ready && !pick1;
    assign res1_ready = up_ready && pick1;

    always_ff @(posedge clk) begin
        if (reset) begin
            grant <= 1'b0;
        end else if (up_valid && up_ready) begin
            grant <= !pick1;
        end
    end

    a_one_ready: assert property (
        @(posedge clk) disable iff (reset)
        !(res0_ready && res1_ready)
    );

endmodule

/* hdl/root_controller.sv */
module root_controller (
    input  logic                         clk,
    input  logic                         reset,

    input  logic [msg_pkg::MSG_WIDTH-1:0] data_from_cpu,
    input  logic                         valid_from_cpu,
    output logic                         ready_from_cpu,

    output logic [msg_pkg::MSG_WIDTH-1:0] data_to_cpu,
    output logic                         valid_to_cpu,
    input  logic                         ready_to_cpu,

    output logic [msg_pkg::MSG_WIDTH-1:0] data_to_fpgas,
    output logic                         valid_to_fpgas,
    input  logic                         ready_to_fpgas,

    input  logic [msg_pkg::MSG_WIDTH-1:0] data_from_fpgas,
    input  logic                         valid_from_fpgas,
    output logic                         ready_from_fpgas
);

    import msg_pkg::*;
    import tree_pkg::*;

    root_stage_e stage;
    logic report_all;
    logic [RETURN_COUNT_WIDTH-1:0] return_count;
    logic [COUNT_WIDTH-1:0] total_defects;
    logic [COUNT_WIDTH-1:0] max_cycles;

    msg_word_u cpu_word;
    msg_word_u fpga_word;
    msg_word_u bcast_word;
    msg_word_u summary_word;

    logic is_decode;
    logic cmd_fire;
    logic result_fire;
    logic all_in;

    assign cpu_word  = data_from_cpu;
    assign fpga_word = data_from_fpgas;

    // only decode-block to the root goes down the tree
    assign is_decode = (cpu_word.cmd.dest == DEST_ROOT) &&
                       (cpu_word.cmd.header == HEADER_DECODE_BLOCK);

    assign all_in = (return_count == RETURN_COUNT_WIDTH'(NUM_CHILDREN));

    // rewrite as broadcast, everything else passes as is
    always_comb begin
        bcast_word = cpu_word;
        bcast_word.cmd.dest = DEST_BROADCAST;
    end

    // cpu side accepts only while idle and the leaves can take it
    assign ready_from_cpu = (stage == STAGE_IDLE) && ready_to_fpgas;
    assign cmd_fire       = valid_from_cpu && ready_from_cpu;
    assign data_to_fpgas  = bcast_word;
    assign valid_to_fpgas = cmd_fire && is_decode;

    always_comb begin
        summary_word = '0;
        summary_word.res.dest     = DEST_ROOT;
        summary_word.res.header   = HEADER_SUMMARY;
        summary_word.res.leaf_id  = 8'h00;
        summary_word.res.defects  = total_defects;
        summary_word.res.cycles   = max_cycles;
    end

    // leaf results up to the cpu
    always_comb begin
        data_to_cpu      = summary_word;
        valid_to_cpu     = 1'b0;
        ready_from_fpgas = 1'b0;
        if (stage == STAGE_WAIT_RESULTS) begin
            if (all_in) begin
                valid_to_cpu = 1'b1;
            end else if (report_all) begin
                // pass each result through untouched
                data_to_cpu      = data_from_fpgas;
                valid_to_cpu     = valid_from_fpgas;
                ready_from_fpgas = ready_to_cpu;
            end else begin
                ready_from_fpgas = 1'b1;
            end
        end
    end

    assign result_fire = valid_from_fpgas && ready_from_fpgas &&
                         (fpga_word.res.header == HEADER_RESULT);

    always_ff @(posedge clk) begin
        if (reset) begin
            stage        <= STAGE_IDLE;
            report_all   <= 1'b0;
            return_count <= '0;
        end else begin
            case (stage)
                STAGE_IDLE: begin
                    if (cmd_fire && is_decode) begin
                        stage         <= STAGE_WAIT_RESULTS;
                        report_all    <= cpu_word.cmd.flags[FLAG_REPORT_ALL_BIT];
                        return_count  <= '0;
                        total_defects <= '0;
                        max_cycles    <= '0;
                    end
                end
                STAGE_WAIT_RESULTS: begin
                    if (result_fire) begin
                        return_count  <= return_count + 1'b1;
                        total_defects <= total_defects + fpga_word.res.defects;
                        if (fpga_word.res.cycles > max_cycles) begin
                            max_cycles <= fpga_word.res.cycles;
                        end
                    end else if (all_in && ready_to_cpu) begin
                        // summary taken this cycle
                        stage      <= STAGE_IDLE;
                        report_all <= 1'b0;
                    end
                end
                default: begin
                    stage <= STAGE_IDLE;
                end
            endcase
        end
    end

    // no new broadcast while results are still out
    a_bcast_only_idle: assert property (
        @(posedge clk) disable iff (reset)
        valid_to_fpgas |-> (stage == STAGE_IDLE)
    );

    a_return_count_bound: assert property (
        @(posedge clk) disable iff (reset)
        return_count <= RETURN_COUNT_WIDTH'(NUM_CHILDREN)
    );

endmodule

/* hdl/decoder_tree_top.sv */
module decoder_tree_top (
    input  logic                         clk,
    input  logic                         reset,

    input  logic [msg_pkg::MSG_WIDTH-1:0] data_from_cpu,
    input  logic                         valid_from_cpu,
    output logic                         ready_from_cpu,

    output logic [msg_pkg::MSG_WIDTH-1:0] data_to_cpu,
    output logic                         valid_to_cpu,
    input  logic                         ready_to_cpu
);

    import msg_pkg::*;
    import tree_pkg::*;

    logic [MSG_WIDTH-1:0] data_to_fpgas;
    logic valid_to_fpgas;
    logic ready_to_fpgas;
    logic [MSG_WIDTH-1:0] data_from_fpgas;
    logic valid_from_fpgas;
    logic ready_from_fpgas;

    logic leaf_cmd_valid;
    logic [NUM_CHILDREN-1:0] leaf_cmd_ready;
    logic [MSG_WIDTH-1:0] leaf_res_data [NUM_CHILDREN];
    logic [NUM_CHILDREN-1:0] leaf_res_valid;
    logic [NUM_CHILDREN-1:0] leaf_res_ready;

    root_controller root0 (
        .clk              (clk),
        .reset            (reset),
        .data_from_cpu    (data_from_cpu),
        .valid_from_cpu   (valid_from_cpu),
        .ready_from_cpu   (ready_from_cpu),
        .data_to_cpu      (data_to_cpu),
        .valid_to_cpu     (valid_to_cpu),
        .ready_to_cpu     (ready_to_cpu),
        .data_to_fpgas    (data_to_fpgas),
        .valid_to_fpgas   (valid_to_fpgas),
        .ready_to_fpgas   (ready_to_fpgas),
        .data_from_fpgas  (data_from_fpgas),
        .valid_from_fpgas (valid_from_fpgas),
        .ready_from_fpgas (ready_from_fpgas)
    );

    child_link_hub hub0 (
        .clk         (clk),
        .reset       (reset),
        .bcast_valid (valid_to_fpgas),
        .bcast_ready (ready_to_fpgas),
        .cmd_valid   (leaf_cmd_valid),
        .cmd0_ready  (leaf_cmd_ready[0]),
        .cmd1_ready  (leaf_cmd_ready[1]),
        .res0_data   (leaf_res_data[0]),
        .res0_valid  (leaf_res_valid[0]),
        .res0_ready  (leaf_res_ready[0]),
        .res1_data   (leaf_res_data[1]),
        .res1_valid  (leaf_res_valid[1]),
        .res1_ready  (leaf_res_ready[1]),
        .up_data     (data_from_fpgas),
        .up_valid    (valid_from_fpgas),
        .up_ready    (ready_from_fpgas)
    );

    // command data goes straight from the root to both leaves
    leaf_decoder #(.LEAF_ID(0)) leaf0 (
        .clk       (clk),
        .reset     (reset),
        .cmd_data  (data_to_fpgas),
        .cmd_valid (leaf_cmd_valid),
        .cmd_ready (leaf_cmd_ready[0]),
        .res_data  (leaf_res_data[0]),
        .res_valid (leaf_res_valid[0]),
        .res_ready (leaf_res_ready[0])
    );

    leaf_decoder #(.LEAF_ID(1)) leaf1 (
        .clk       (clk),
        .reset     (reset),
        .cmd_data  (data_to_fpgas),
        .cmd_valid (leaf_cmd_valid),
        .cmd_ready (leaf_cmd_ready[1]),
        .res_data  (leaf_res_data[1]),
        .res_valid (leaf_res_valid[1]),
        .res_ready (leaf_res_ready[1])
    );

endmodule

/* sim/tb_decoder_tree.sv */
module tb_decoder_tree;

    timeunit 1ns;
    timeprecision 100ps;

    import msg_pkg::*;

    localparam int NUM_FIXED    = 7;
    localparam int NUM_RANDOM   = 6;
    localparam int NUM_ENTRIES  = NUM_FIXED + NUM_RANDOM;
    localparam int ACCEPT_LIMIT = 20;
    localparam int WORD_LIMIT   = 80;
    // longer than the slowest leaf scan
    localparam int QUIET_WINDOW = 60;

    logic clk;
    logic reset;
    logic [MSG_WIDTH-1:0] data_from_cpu;
    logic valid_from_cpu;
    logic ready_from_cpu;
    logic [MSG_WIDTH-1:0] data_to_cpu;
    logic valid_to_cpu;
    logic ready_to_cpu;

    // stimulus table
    logic [7:0]  tab_dest [NUM_ENTRIES];
    logic [7:0]  tab_header [NUM_ENTRIES];
    logic [31:0] tab_syndrome [NUM_ENTRIES];
    logic        tab_report [NUM_ENTRIES];
    int          tab_stall [NUM_ENTRIES];

    integer seed;

    decoder_tree_top dut0 (
        .clk            (clk),
        .reset          (reset),
        .data_from_cpu  (data_from_cpu),
        .valid_from_cpu (valid_from_cpu),
        .ready_from_cpu (ready_from_cpu),
        .data_to_cpu    (data_to_cpu),
        .valid_to_cpu   (valid_to_cpu),
        .ready_to_cpu   (ready_to_cpu)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic int count_ones(input logic [15:0] bits);
        int n;
        n = 0;
        for (int i = 0; i < 16; i++) begin
            n += int'(bits[i]);
        end
        return n;
    endfunction

    // one scan cycle per bit plus one pairing cycle per defect
    function automatic logic [63:0] leaf_word(input int leaf, input logic [15:0] slice);
        int pop;
        pop = count_ones(slice);
        return {DEST_ROOT, HEADER_RESULT, 8'(leaf), 8'h00, 16'(pop), 16'(16 + pop)};
    endfunction

    function automatic logic [63:0] summary_word(input logic [31:0] syn);
        int pop0;
        int pop1;
        int longest;
        pop0 = count_ones(syn[15:0]);
        pop1 = count_ones(syn[31:16]);
        longest = (pop0 > pop1) ? pop0 : pop1;
        return {DEST_ROOT, HEADER_SUMMARY, 8'h00, 8'h00, 16'(pop0 + pop1), 16'(16 + longest)};
    endfunction

    task automatic stop_run();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("ERR time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
            stop_run();
        end
    endtask

    task automatic set_entry(input int idx, input logic [7:0] dest, input logic [7:0] header,
                             input logic [31:0] syn, input logic report, input int stall);
        tab_dest[idx]     = dest;
        tab_header[idx]   = header;
        tab_syndrome[idx] = syn;
        tab_report[idx]   = report;
        tab_stall[idx]    = stall;
    endtask

    task automatic load_table();
        set_entry(0, DEST_ROOT, HEADER_DECODE_BLOCK, 32'h0000_0000, 1'b0, 0);
        set_entry(1, DEST_ROOT, HEADER_DECODE_BLOCK, 32'hffff_ffff, 1'b0, 3);
        set_entry(2, DEST_ROOT, HEADER_DECODE_BLOCK, 32'h0000_ffff, 1'b1, 0);
        // wrong dest, then a non-decode header
        set_entry(3, DEST_BROADCAST, HEADER_DECODE_BLOCK, 32'h1234_5678, 1'b0, 0);
        set_entry(4, DEST_ROOT, 8'h01, 32'hdead_beef, 1'b0, 0);
        set_entry(5, DEST_ROOT, HEADER_DECODE_BLOCK, 32'h8001_0003, 1'b1, 4);
        set_entry(6, DEST_ROOT, HEADER_DECODE_BLOCK, 32'ha5a5_f00f, 1'b0, 2);
        for (int i = NUM_FIXED; i < NUM_ENTRIES; i++) begin
            set_entry(i, DEST_ROOT, HEADER_DECODE_BLOCK, $random(seed),
                      1'({$random(seed)} % 2), {$random(seed)} % 4);
        end
    endtask

    task automatic wait_cmd_accept();
        int n;
        n = 0;
        @(negedge clk);
        while (!ready_from_cpu) begin
            n++;
            if (n > ACCEPT_LIMIT) begin
                $display("timeout: the root never accepted a command from the CPU");
                stop_run();
            end
            @(negedge clk);
        end
    endtask

    task automatic wait_cpu_word(output logic [63:0] word);
        int n;
        n = 0;
        @(negedge clk);
        while (!valid_to_cpu) begin
            n++;
            if (n > WORD_LIMIT) begin
                $display("timeout: no word from the root reached the CPU");
                stop_run();
            end
            @(negedge clk);
        end
        word = data_to_cpu;
    endtask

    task automatic check_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_value("valid_to_cpu", 0, valid_to_cpu);
        end
    endtask

    task automatic send_command(input int idx);
        @(posedge clk);
        data_from_cpu  <= {tab_dest[idx], tab_header[idx], tab_syndrome[idx],
                           16'(tab_report[idx]) << FLAG_REPORT_ALL_BIT};
        valid_from_cpu <= 1'b1;
        ready_to_cpu   <= tab_report[idx] || (tab_stall[idx] == 0);
        wait_cmd_accept();
        // acceptance edge
        @(posedge clk);
        valid_from_cpu <= 1'b0;
    endtask

    task automatic collect_results(input int idx);
        logic [63:0] word;
        logic [1:0] seen;
        seen = 2'b00;
        repeat (2) begin
            wait_cpu_word(word);
            check_value("result header", HEADER_RESULT, word[55:48]);
            if (word[47:40] == 8'd0) begin
                check_value("leaf 0 result", leaf_word(0, tab_syndrome[idx][15:0]), word);
            end else begin
                check_value("leaf 1 result", leaf_word(1, tab_syndrome[idx][31:16]), word);
            end
            seen[word[40]] = 1'b1;
            @(posedge clk);
            // summary shows up right after the last result
            if (seen == 2'b11) begin
                ready_to_cpu <= (tab_stall[idx] == 0);
            end
        end
        check_value("leaf ids reported", 2'b11, seen);
    endtask

    task automatic take_summary(input int idx);
        logic [63:0] word;
        wait_cpu_word(word);
        check_value("summary word", summary_word(tab_syndrome[idx]), word);
        repeat (tab_stall[idx]) begin
            @(posedge clk);
            @(negedge clk);
            check_value("valid_to_cpu under stall", 1, valid_to_cpu);
            check_value("data_to_cpu under stall", word, data_to_cpu);
            check_value("ready_from_cpu under stall", 0, ready_from_cpu);
        end
        if (tab_stall[idx] > 0) begin
            @(posedge clk);
            ready_to_cpu <= 1'b1;
            @(negedge clk);
            check_value("valid_to_cpu", 1, valid_to_cpu);
        end
        check_value("ready_from_cpu", 0, ready_from_cpu);
        // summary transfer
        @(posedge clk);
        @(negedge clk);
        check_value("valid_to_cpu after summary", 0, valid_to_cpu);
        check_value("ready_from_cpu after summary", 1, ready_from_cpu);
        check_quiet(3);
    endtask

    task automatic apply_entry(input int idx);
        logic forwarded;
        forwarded = (tab_dest[idx] == DEST_ROOT) && (tab_header[idx] == HEADER_DECODE_BLOCK);
        send_command(idx);
        if (!forwarded) begin
            check_quiet(QUIET_WINDOW);
            check_value("ready_from_cpu after dropped command", 1, ready_from_cpu);
        end else begin
            if (tab_report[idx]) begin
                collect_results(idx);
            end
            take_summary(idx);
        end
    endtask

    initial begin
        seed           = 22;
        reset          = 1'b1;
        data_from_cpu  = '0;
        valid_from_cpu = 1'b0;
        ready_to_cpu   = 1'b1;
        load_table();
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("valid_to_cpu after reset", 0, valid_to_cpu);
        check_value("ready_from_cpu after reset", 1, ready_from_cpu);
        for (int idx = 0; idx < NUM_ENTRIES; idx++) begin
            apply_entry(idx);
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

/* all.f */
hdl/msg_pkg.sv
hdl/tree_pkg.sv
hdl/leaf_decoder.sv
hdl/child_link_hub.sv
hdl/root_controller.sv
hdl/decoder_tree_top.sv
sim/tb_decoder_tree.sv

/* Makefile */
# Verilator build and run for the decoder tree testbench

VERILATOR ?= verilator
TOP       ?= tb_decoder_tree
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= NO ERRORS
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
